// File: verilog/spi_mem_pkg.sv
package spi_mem_pkg;

    // ----------------------------------------------------------------------
    // storage types
    // ----------------------------------------------------------------------

    // 128 entries, so seven address bits
    typedef logic [6:0] addr_t;

    // one memory byte, also the shift register width
    typedef logic [7:0] data_t;

    // bit position in a frame, 0 up to 16
    typedef logic [4:0] bit_count_t;

    // ----------------------------------------------------------------------
    // sequencer states
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        st_idle,
        st_get_cmd,
        st_read_load,
        st_read_shift,
        st_write_shift,
        st_done
    } spi_state_t;

    // frame layout: address + r/w flag, then one data byte
    localparam bit_count_t CMD_BITS   = 5'd8;
    localparam bit_count_t DATA_BITS  = 5'd8;
    localparam bit_count_t FRAME_BITS = CMD_BITS + DATA_BITS;

endpackage

// File: verilog/spi_ctrl_if.sv
`timescale 1ns/10ps

interface spi_ctrl_if;

    // load shift register from memory read port
    logic sr_load;
    // capture command address into the latch
    logic addr_we;
    // commit the shifted-in byte to memory
    logic dm_we;
    // miso drive enable
    logic miso_oe;
    // latched r/w flag of the current command
    logic cmd_read;

    // sequencer side
    modport ctrl (output sr_load, output addr_we, output dm_we, output miso_oe,
                  output cmd_read);

    // datapath side
    modport dp (input sr_load, input addr_we, input dm_we, input miso_oe,
                input cmd_read);

endinterface

// File: verilog/input_conditioner.sv
`timescale 1ns/10ps

module input_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pin,
    output logic level,
    output logic rise,
    output logic fall
);

    // counter has to reach DEBOUNCE_CYCLES
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 2);

    logic             sync_0;
    logic             sync_1;
    logic [CNT_W-1:0] stable_cnt;
    logic             accept;

    // new level accepted once the mismatch lasted DEBOUNCE_CYCLES+1 cycles
    assign accept = (sync_1 != level) && (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_0     <= 1'b0;
            sync_1     <= 1'b0;
            stable_cnt <= '0;
            level      <= 1'b0;
            rise       <= 1'b0;
            fall       <= 1'b0;
        end else begin
            // two-flop synchronizer
            sync_0 <= pin;
            sync_1 <= sync_0;
            // glitch shorter than the window restarts the count
            if (sync_1 == level || accept) begin
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (accept) begin
                level <= sync_1;
            end
            // pulses line up with the level change
            rise <= accept && sync_1;
            fall <= accept && !sync_1;
        end
    end

endmodule

// File: verilog/spi_shift_register.sv
`timescale 1ns/10ps

module spi_shift_register (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               shift_en,
    input  logic               load,
    input  spi_mem_pkg::data_t load_data,
    input  logic               serial_in,
    input  logic               out_en,
    output spi_mem_pkg::data_t contents,
    output logic               serial_out
);

    // ----------------------------------------------------------------------
    // shift stage
    // ----------------------------------------------------------------------

    // parallel load wins over a shift in the same cycle
    always_ff @(posedge clk) begin
        if (load) begin
            contents <= load_data;
        end else if (shift_en) begin
            // msb first on the wire, new bit enters at bit 0
            contents <= {contents[$bits(contents)-2:0], serial_in};
        end
    end

    // ----------------------------------------------------------------------
    // output stage
    // ----------------------------------------------------------------------

    // msb sampled on sclk fall, holds through the next rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            serial_out <= 1'b0;
        end else if (out_en) begin
            serial_out <= contents[$bits(contents)-1];
        end
    end

endmodule

// File: verilog/spi_fsm.sv
`timescale 1ns/10ps

module spi_fsm (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sclk_rise,
    input  logic     cs_active_n,
    input  logic     cmd_lsb,
    spi_ctrl_if.ctrl ctrl
);

    import spi_mem_pkg::*;

    // counts of the last command bit and the last data bit
    localparam bit_count_t LAST_CMD_BIT   = CMD_BITS - bit_count_t'(1);
    localparam bit_count_t LAST_FRAME_BIT = FRAME_BITS - bit_count_t'(1);

    spi_state_t state;
    bit_count_t bit_count;
    logic       dm_we_q;
    logic       in_frame;

    assign in_frame = !cs_active_n;

    // ----------------------------------------------------------------------
    // state and bit counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            bit_count     <= '0;
            dm_we_q       <= 1'b0;
            ctrl.cmd_read <= 1'b0;
        end else begin
            // write strobe lasts one cycle
            dm_we_q <= 1'b0;
            if (state != st_idle && !in_frame) begin
                // cs released mid-frame or at the end, nothing committed
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        bit_count <= '0;
                        if (in_frame) begin
                            state <= st_get_cmd;
                        end
                    end
                    st_get_cmd: begin
                        if (sclk_rise) begin
                            bit_count <= bit_count + bit_count_t'(1);
                            if (bit_count == LAST_CMD_BIT) begin
                                state <= st_read_load;
                            end
                        end
                    end
                    // command byte now complete in the shift register
                    st_read_load: begin
                        ctrl.cmd_read <= cmd_lsb;
                        state         <= cmd_lsb ? st_read_shift : st_write_shift;
                    end
                    st_read_shift: begin
                        if (sclk_rise) begin
                            bit_count <= bit_count + bit_count_t'(1);
                            if (bit_count == LAST_FRAME_BIT) begin
                                state <= st_done;
                            end
                        end
                    end
                    st_write_shift: begin
                        if (sclk_rise) begin
                            bit_count <= bit_count + bit_count_t'(1);
                            // data byte lands in the shift register this edge
                            if (bit_count == LAST_FRAME_BIT) begin
                                dm_we_q <= 1'b1;
                                state   <= st_done;
                            end
                        end
                    end
                    // hold until the master lets go of cs
                    st_done: begin
                        bit_count <= bit_count;
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // control strobes
    // ----------------------------------------------------------------------
    always_comb begin
        // address taken on every command, read or write
        ctrl.addr_we = (state == st_read_load) && in_frame;
        ctrl.sr_load = ctrl.addr_we && cmd_lsb;
        // drive miso only for the data half of a read
        ctrl.miso_oe = ctrl.sr_load || ((state == st_read_shift) && in_frame);
        ctrl.dm_we   = dm_we_q;
    end

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/10ps

module data_memory (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  spi_mem_pkg::addr_t addr,
    input  spi_mem_pkg::data_t wdata,
    output spi_mem_pkg::data_t rdata
);

    import spi_mem_pkg::*;

    // one entry per address value
    localparam int DEPTH = 2 ** $bits(addr_t);

    data_t mem [DEPTH];

    // whole array cleared on reset, so unwritten reads return zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read port is combinational
    assign rdata = mem[addr];

endmodule

// File: verilog/spi_memory.sv
`timescale 1ns/10ps

module spi_memory #(
    parameter int DEBOUNCE_CYCLES = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);

    import spi_mem_pkg::*;

    logic  sclk_rise;
    logic  sclk_fall;
    logic  cs_level;
    logic  mosi_level;
    data_t sr_contents;
    data_t mem_rdata;
    addr_t addr_q;
    addr_t mem_addr;
    logic  mem_we;

    spi_ctrl_if ctrl_bus ();

    // ----------------------------------------------------------------------
    // pin conditioning
    // ----------------------------------------------------------------------

    // sclk edges drive sampling and miso update
    input_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_sclk_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .pin   (sclk),
        .level (),
        .rise  (sclk_rise),
        .fall  (sclk_fall)
    );

    // chip select used as a level only
    input_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_cs_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .pin   (cs_n),
        .level (cs_level),
        .rise  (),
        .fall  ()
    );

    input_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_mosi_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .pin   (mosi),
        .level (mosi_level),
        .rise  (),
        .fall  ()
    );

    // ----------------------------------------------------------------------
    // sequencer and datapath
    // ----------------------------------------------------------------------

    // bit 0 of the command byte is the r/w flag
    spi_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .sclk_rise   (sclk_rise),
        .cs_active_n (cs_level),
        .cmd_lsb     (sr_contents[0]),
        .ctrl        (ctrl_bus.ctrl)
    );

    spi_shift_register u_shift (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_en   (sclk_rise),
        .load       (ctrl_bus.sr_load),
        .load_data  (mem_rdata),
        .serial_in  (mosi_level),
        .out_en     (sclk_fall),
        .contents   (sr_contents),
        .serial_out (miso)
    );

    // address latch, upper seven command bits
    always_ff @(posedge clk) begin
        if (ctrl_bus.addr_we) begin
            addr_q <= sr_contents[$bits(data_t)-1:1];
        end
    end

    // read load shares the addr_we cycle, so bypass the latch then
    assign mem_addr = ctrl_bus.addr_we ? sr_contents[$bits(data_t)-1:1] : addr_q;
    // never write during a read command
    assign mem_we   = ctrl_bus.dm_we && !ctrl_bus.cmd_read;

    data_memory u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (sr_contents),
        .rdata (mem_rdata)
    );

    assign miso_oe = ctrl_bus.miso_oe;

endmodule

// File: dv/spi_memory_tb.sv
`timescale 1ns/10ps

module spi_memory_tb;

    import spi_mem_pkg::*;

    // ----------------------------------------------------------------------
    // frame and timing constants
    // ----------------------------------------------------------------------

    // sclk half period in clk cycles, well above 3*(DEBOUNCE_CYCLES+4)
    localparam int HALF_CLKS  = 16;
    localparam int CMD_LEN    = int'(CMD_BITS);
    localparam int FRAME_LEN  = int'(CMD_BITS) + int'(DATA_BITS);
    // aborted write stops after this many bits
    localparam int ABORT_BITS = 12;
    // watchdog budget per stimulus line
    localparam int WATCH_BITS = 17;
    localparam int WATCH_MARGIN = 2000;

    logic clk;
    logic rst_n;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic miso_oe;

    // transactions read from the stimulus file
    string tx_kind [$];
    addr_t tx_addr [$];
    data_t tx_wdata [$];
    data_t tx_expect [$];

    integer seed;
    int     tx_count;
    int     error_count;
    int     test_errors;
    int     pass_count;
    int     fail_count;
    logic   loaded;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    spi_memory #(.DEBOUNCE_CYCLES(1)) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    // lands 1 ns after a rising clk edge
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    code;
        string kind;
        string rest;
        addr_t addr;
        data_t wdata;
        data_t exp_data;
        fd = $fopen("dv/spi_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/spi_stimulus.txt");
            error_count++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind[0] == "#") begin
                    // comment line, drop the rest of it
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h", addr, wdata, exp_data);
                    if (code != 3) begin
                        $display("malformed stimulus line after kind %s", kind);
                        error_count++;
                    end else if (kind != "write" && kind != "read" && kind != "abort") begin
                        $display("unknown transaction kind %s in stimulus file", kind);
                        error_count++;
                    end else begin
                        tx_kind.push_back(kind);
                        tx_addr.push_back(addr);
                        tx_wdata.push_back(wdata);
                        tx_expect.push_back(exp_data);
                    end
                end
            end
            $fclose(fd);
        end
        tx_count = tx_kind.size();
    endtask

    // ----------------------------------------------------------------------
    // SPI master, mode 0
    // ----------------------------------------------------------------------

    // nbits below FRAME_LEN releases cs mid-frame
    task automatic run_frame(input addr_t addr, input logic rd, input data_t wdata,
                             input int nbits, output data_t rdata);
        logic [FRAME_LEN-1:0] frame;
        string                oe_name;
        frame = {addr, rd, wdata};
        rdata = '0;
        cs_n  = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            // mosi moves while sclk is low
            mosi = frame[FRAME_LEN-1-i];
            wait_clks(HALF_CLKS);
            // sample right before the rising edge
            oe_name = $sformatf("miso_oe bit %0d", i + 1);
            check_bit(oe_name, rd && (i >= CMD_LEN), miso_oe);
            if (i >= CMD_LEN) begin
                rdata = {rdata[6:0], miso};
            end
            sclk = 1'b1;
            wait_clks(HALF_CLKS);
            sclk = 1'b0;
        end
        wait_clks(HALF_CLKS);
        // drive window over, miso released before cs goes high
        check_bit("miso_oe after frame", 1'b0, miso_oe);
        cs_n = 1'b1;
        mosi = 1'b0;
        // idle cs long enough for the conditioner
        wait_clks(HALF_CLKS);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        data_t rdata;
        logic  rd;
        int    nbits;
        int    gap;
        rst_n       = 1'b0;
        sclk        = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        seed        = 32'h48df_214d;
        error_count = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        loaded      = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // cs level starts low out of reset, let it settle high
        wait_clks(HALF_CLKS);
        for (int t = 0; t < tx_count; t++) begin
            test_errors = 0;
            rd    = (tx_kind[t] == "read");
            nbits = (tx_kind[t] == "abort") ? ABORT_BITS : FRAME_LEN;
            run_frame(tx_addr[t], rd, tx_wdata[t], nbits, rdata);
            if (rd) begin
                check_data("miso", tx_expect[t], rdata);
            end
            if (test_errors == 0) begin
                pass_count++;
                $display("test %0d %s addr 0x%h ok", t, tx_kind[t], tx_addr[t]);
            end else begin
                fail_count++;
                $display("test %0d %s addr 0x%h failed", t, tx_kind[t], tx_addr[t]);
            end
            error_count += test_errors;
            // random idle gap of 0 to 7 cycles
            gap = $random(seed) & 32'h7;
            if (gap > 0) begin
                wait_clks(gap);
            end
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0 && tx_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // budget grows with the number of stimulus lines
    initial begin
        wait (loaded);
        repeat (tx_count * WATCH_BITS * 2 * HALF_CLKS + WATCH_MARGIN) @(posedge clk);
        $display("watchdog timeout, transactions did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: dv/spi_stimulus.txt
# columns are kind, address, write data and expected read data
# numbers in hex and abort stops a write after twelve bits
read  05 00 00
write 05 a5 00
read  05 00 a5
read  7f 00 00
write 7f 3c 00
read  7f 00 3c
write 12 5a 00
abort 12 ff 00
read  12 00 5a
abort 33 c3 00
read  33 00 00
write 00 01 00
write 01 80 00
write 40 ff 00
write 2a 96 00
write 55 6e 00
read  55 00 6e
read  00 00 01
read  2a 00 96
read  40 00 ff
read  01 00 80
write 05 00 00
read  05 00 00

// File: spi_memory.f
verilog/spi_mem_pkg.sv
verilog/spi_ctrl_if.sv
verilog/input_conditioner.sv
verilog/spi_shift_register.sv
verilog/spi_fsm.sv
verilog/data_memory.sv
verilog/spi_memory.sv
dv/spi_memory_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the SPI memory testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=spi_memory_tb
LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 \
    --top-module "$TOP" \
    -f spi_memory.f \
    -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -qF "*** PASSED ***" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
